// ==== include/hd_params.svh ====
`ifndef HD_PARAMS_SVH
`define HD_PARAMS_SVH

// ============================================================
// encoder geometry
// ============================================================

// cores working in lockstep, one input lane each
`define HD_N_CORES      4
// bits per hypervector
`define HD_DIM          32
// item index bits per lane
`define HD_LANE_W       4
// entries in each item memory
`define HD_ITEM_DEPTH   16

// register map
`define HD_REG_CTRL     0
`define HD_REG_COUNT    1

`endif

// ==== hdl/hd_pkg.sv ====
`include "hd_params.svh"

package hd_pkg;

    // one hypervector
    typedef logic [`HD_DIM-1:0] hv_t;
    // item memory index
    typedef logic [`HD_LANE_W-1:0] item_t;
    // per-bit counter, also the beat counter (bundles up to 255)
    typedef logic [7:0] count_t;
    // item count, 1 to depth, so one bit wider than the index
    typedef logic [$clog2(`HD_ITEM_DEPTH):0] items_t;

    // input beat, one index per core lane
    typedef logic [`HD_N_CORES*`HD_LANE_W-1:0] lanes_t;
    // output beat, one hypervector per core
    typedef logic [`HD_N_CORES*`HD_DIM-1:0] results_t;

    // register port
    typedef logic [1:0] reg_addr_t;
    typedef logic [31:0] word_t;

    // generator sequencing
    typedef enum logic [1:0] {gen_idle, gen_fill, gen_tie} gen_state_t;

endpackage

// ==== hdl/hd_regs.sv ====
`timescale 1ns/100ps

`include "hd_params.svh"

module hd_regs import hd_pkg::*; (
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    input  logic      reg_wr,
    input  reg_addr_t reg_addr,
    input  word_t     reg_wdata,
    input  logic      gen_done,
    output logic      gen,
    output logic      run,
    output items_t    item_count
);

    // ============================================================
    // control and count registers
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            run        <= 1'b0;
            // full memory by default
            item_count <= items_t'(`HD_ITEM_DEPTH);
        end else if (reg_wr) begin
            case (reg_addr)
                reg_addr_t'(`HD_REG_CTRL): begin
                    // bit 0 gen, bit 1 run
                    gen <= reg_wdata[0];
                    run <= reg_wdata[1];
                end
                reg_addr_t'(`HD_REG_COUNT): begin
                    item_count <= reg_wdata[$bits(items_t)-1:0];
                end
                default: begin
                    // unmapped, write dropped
                end
            endcase
        end else if (gen_done) begin
            // generate phase ends by itself
            gen <= 1'b0;
        end
    end

endmodule

// ==== hdl/item_generator.sv ====
`timescale 1ns/100ps

module item_generator import hd_pkg::*; (
    input  logic   AXIS_ACLK,
    input  logic   S_AXI_ARESETN,
    input  logic   gen,
    input  items_t item_count,
    output logic   im_we,
    output item_t  im_addr,
    output hv_t    im_data,
    output hv_t    tie_hv,
    output logic   gen_done
);

    localparam hv_t seed = 32'h2463534a;

    gen_state_t state;
    hv_t        rng;
    hv_t        rng_next;
    item_t      addr;
    logic       fill_last;

    // xorshift32, 13 / 17 / 5
    function automatic hv_t xs_step(input hv_t x);
        hv_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign rng_next  = xs_step(rng);
    // final entry is count minus 1
    assign fill_last = ({1'b0, addr} == (item_count - items_t'(1)));

    // write port shared by every core copy
    assign im_we    = (state == gen_fill);
    assign im_addr  = addr;
    assign im_data  = rng_next;
    // one cycle in tie, regs drop gen on this
    assign gen_done = (state == gen_tie);

    // ============================================================
    // sequencing
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            // seed restarts outside the generate phase
            state <= gen_idle;
            rng   <= seed;
            addr  <= '0;
        end else begin
            case (state)
                gen_idle: begin
                    state <= gen_fill;
                    addr  <= '0;
                end
                gen_fill: begin
                    rng  <= rng_next;
                    addr <= addr + item_t'(1);
                    if (fill_last) begin
                        state <= gen_tie;
                    end
                end
                default: begin
                    state <= gen_idle;
                end
            endcase
        end
    end

    // next word after the last entry
    always_ff @(posedge AXIS_ACLK) begin
        if (state == gen_tie) begin
            tie_hv <= rng_next;
        end
    end

endmodule

// ==== hdl/input_dispatch.sv ====
`timescale 1ns/100ps

module input_dispatch import hd_pkg::*; (
    input  logic   AXIS_ACLK,
    input  logic   S_AXI_ARESETN,
    input  logic   run,
    input  logic   gen,
    input  logic   in_tvalid,
    input  lanes_t in_tdata,
    input  logic   in_tlast,
    output logic   in_tready,
    input  logic   drained,
    output logic   beat_v,
    output logic   beat_last,
    output lanes_t beat_lanes
);

    logic pending;
    logic accept;

    // blocked in generate phase and while a result waits
    assign in_tready = run & ~gen & ~pending;
    assign accept    = in_tvalid & in_tready;

    // ============================================================
    // beat broadcast and busy flag
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            beat_v    <= 1'b0;
            beat_last <= 1'b0;
            pending   <= 1'b0;
        end else begin
            beat_v    <= accept;
            beat_last <= accept & in_tlast;
            // held from last beat until output handshake
            if (accept && in_tlast) begin
                pending <= 1'b1;
            end else if (drained) begin
                pending <= 1'b0;
            end
        end
    end

    // lane indices, only meaningful with beat_v
    always_ff @(posedge AXIS_ACLK) begin
        if (accept) begin
            beat_lanes <= in_tdata;
        end
    end

endmodule

// ==== hdl/hd_core.sv ====
`timescale 1ns/100ps

`include "hd_params.svh"

module hd_core import hd_pkg::*; (
    input  logic  AXIS_ACLK,
    input  logic  S_AXI_ARESETN,
    input  logic  im_we,
    input  item_t im_addr,
    input  hv_t   im_data,
    input  hv_t   tie_hv,
    input  logic  beat_v,
    input  logic  beat_last,
    input  item_t beat_item,
    output logic  result_v,
    output hv_t   result
);

    hv_t    item_mem [`HD_ITEM_DEPTH];
    hv_t    item_hv;
    count_t cnt [`HD_DIM];
    count_t cnt_next [`HD_DIM];
    count_t beats;
    count_t beats_next;
    hv_t    maj;

    // ============================================================
    // item memory, local copy
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (im_we) begin
            item_mem[im_addr] <= im_data;
        end
    end

    // asynchronous lookup
    assign item_hv = item_mem[beat_item];

    // ============================================================
    // accumulate and decide
    // ============================================================

    // counts including the current beat
    always_comb begin
        beats_next = beats + count_t'(1);
        for (int b = 0; b < `HD_DIM; b++) begin
            cnt_next[b] = cnt[b] + count_t'(item_hv[b]);
            // 2*count against beat count, 9 bits wide
            if ({cnt_next[b], 1'b0} > {1'b0, beats_next}) begin
                maj[b] = 1'b1;
            end else if ({cnt_next[b], 1'b0} < {1'b0, beats_next}) begin
                maj[b] = 1'b0;
            end else begin
                // exact tie, even bundle only
                maj[b] = tie_hv[b];
            end
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            beats    <= '0;
            result_v <= 1'b0;
            for (int b = 0; b < `HD_DIM; b++) begin
                cnt[b] <= '0;
            end
        end else begin
            result_v <= beat_v & beat_last;
            if (beat_v) begin
                // last beat closes the bundle, start over
                beats <= beat_last ? '0 : beats_next;
                for (int b = 0; b < `HD_DIM; b++) begin
                    cnt[b] <= beat_last ? '0 : cnt_next[b];
                end
            end
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (beat_v && beat_last) begin
            result <= maj;
        end
    end

endmodule

// ==== hdl/output_stream.sv ====
`timescale 1ns/100ps

module output_stream import hd_pkg::*; (
    input  logic     AXIS_ACLK,
    input  logic     S_AXI_ARESETN,
    input  logic     result_v,
    input  results_t results,
    input  logic     out_tready,
    output logic     out_tvalid,
    output results_t out_tdata,
    output logic     out_tlast,
    output logic     drained
);

    // every beat is a whole packet
    assign out_tlast = out_tvalid;
    // handshake frees the input side
    assign drained   = out_tvalid & out_tready;

    // ============================================================
    // output beat
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            out_tvalid <= 1'b0;
        end else if (result_v) begin
            out_tvalid <= 1'b1;
        end else if (drained) begin
            out_tvalid <= 1'b0;
        end
    end

    // loaded only on result_v
    // input is blocked until drained so data stays stable
    always_ff @(posedge AXIS_ACLK) begin
        if (result_v) begin
            out_tdata <= results;
        end
    end

endmodule

// ==== hdl/hd_top.sv ====
`timescale 1ns/100ps

`include "hd_params.svh"

module hd_top import hd_pkg::*; (
    input  logic      AXIS_ACLK,
    input  logic      S_AXI_ARESETN,
    // register port
    input  logic      reg_wr,
    input  reg_addr_t reg_addr,
    input  word_t     reg_wdata,
    output logic      generating,
    // input stream
    input  logic      in_tvalid,
    input  lanes_t    in_tdata,
    input  logic      in_tlast,
    output logic      in_tready,
    // output stream
    output logic      out_tvalid,
    output results_t  out_tdata,
    output logic      out_tlast,
    input  logic      out_tready
);

    logic     gen;
    logic     run;
    items_t   item_count;
    logic     gen_done;
    logic     im_we;
    item_t    im_addr;
    hv_t      im_data;
    hv_t      tie_hv;
    logic     beat_v;
    logic     beat_last;
    lanes_t   beat_lanes;
    logic     drained;
    logic     [`HD_N_CORES-1:0] core_v;
    logic     results_v;
    results_t results;

    assign generating = gen;
    // cores run in lockstep, all flags rise together
    assign results_v  = &core_v;

    // ============================================================
    // control and generate
    // ============================================================

    hd_regs i_hd_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .gen_done      (gen_done),
        .gen           (gen),
        .run           (run),
        .item_count    (item_count)
    );

    item_generator i_item_generator (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .im_we         (im_we),
        .im_addr       (im_addr),
        .im_data       (im_data),
        .tie_hv        (tie_hv),
        .gen_done      (gen_done)
    );

    // ============================================================
    // datapath
    // ============================================================

    input_dispatch i_input_dispatch (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .gen           (gen),
        .in_tvalid     (in_tvalid),
        .in_tdata      (in_tdata),
        .in_tlast      (in_tlast),
        .in_tready     (in_tready),
        .drained       (drained),
        .beat_v        (beat_v),
        .beat_last     (beat_last),
        .beat_lanes    (beat_lanes)
    );

    // core i: lane i in, slice i out
    for (genvar i = 0; i < `HD_N_CORES; i++) begin : g_core
        hd_core i_hd_core (
            .AXIS_ACLK     (AXIS_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .im_we         (im_we),
            .im_addr       (im_addr),
            .im_data       (im_data),
            .tie_hv        (tie_hv),
            .beat_v        (beat_v),
            .beat_last     (beat_last),
            .beat_item     (beat_lanes[i*`HD_LANE_W +: `HD_LANE_W]),
            .result_v      (core_v[i]),
            .result        (results[i*`HD_DIM +: `HD_DIM])
        );
    end

    output_stream i_output_stream (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .result_v      (results_v),
        .results       (results),
        .out_tready    (out_tready),
        .out_tvalid    (out_tvalid),
        .out_tdata     (out_tdata),
        .out_tlast     (out_tlast),
        .drained       (drained)
    );

endmodule

// ==== bench/tb_hd_top.sv ====
`timescale 1ns/100ps

`include "hd_params.svh"

module tb_hd_top import hd_pkg::*; ();

    // bundle counts per test group
    localparam int n_odd      = 8;
    localparam int n_even     = 8;
    localparam int n_stall    = 8;
    localparam int n_bundles  = 1 + n_odd + n_even + n_stall;
    localparam int max_cycles = n_bundles * 300 + 1000;

    logic      AXIS_ACLK;
    logic      S_AXI_ARESETN;
    logic      reg_wr;
    reg_addr_t reg_addr;
    word_t     reg_wdata;
    logic      generating;
    logic      in_tvalid;
    lanes_t    in_tdata;
    logic      in_tlast;
    logic      in_tready;
    logic      out_tvalid;
    results_t  out_tdata;
    logic      out_tlast;
    logic      out_tready;

    logic [31:0] lfsr;
    int          cycles;
    // reference item memory and tie vector
    hv_t         model_mem [`HD_ITEM_DEPTH];
    hv_t         model_tie;

    hd_top i_hd_top (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .generating    (generating),
        .in_tvalid     (in_tvalid),
        .in_tdata      (in_tdata),
        .in_tlast      (in_tlast),
        .in_tready     (in_tready),
        .out_tvalid    (out_tvalid),
        .out_tdata     (out_tdata),
        .out_tlast     (out_tlast),
        .out_tready    (out_tready)
    );

    // 20 ns clock
    initial begin
        AXIS_ACLK = 1'b0;
        forever begin
            #10 AXIS_ACLK = ~AXIS_ACLK;
        end
    end

    // cycle limit
    always @(posedge AXIS_ACLK) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: no progress within %0d clock cycles", max_cycles);
            $display("Regression failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ============================================================
    // reference model
    // ============================================================

    // xorshift32 step, shifts 13 / 17 / 5
    function automatic hv_t xorshift(input hv_t x);
        hv_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic item_t lane_of(input lanes_t beat, input int c);
        return beat[c*`HD_LANE_W +: `HD_LANE_W];
    endfunction

    // bitwise majority of one core's bundle
    function automatic hv_t majority(input lanes_t beats [$], input int c);
        hv_t r;
        int  ones;
        for (int b = 0; b < `HD_DIM; b++) begin
            ones = 0;
            foreach (beats[k]) begin
                if (model_mem[lane_of(beats[k], c)][b]) begin
                    ones++;
                end
            end
            if (2 * ones > beats.size()) begin
                r[b] = 1'b1;
            end else if (2 * ones < beats.size()) begin
                r[b] = 1'b0;
            end else begin
                // even bundle, exact tie
                r[b] = model_tie[b];
            end
        end
        return r;
    endfunction

    task automatic build_model();
        hv_t x;
        x = 32'h2463534a;
        for (int k = 0; k < `HD_ITEM_DEPTH; k++) begin
            x            = xorshift(x);
            model_mem[k] = x;
        end
        // generator output number 16
        model_tie = xorshift(x);
    endtask

    // ============================================================
    // compare tasks
    // ============================================================

    task automatic check_hv(input string name, input hv_t exp, input hv_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("Regression failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            $display("Regression failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    // ============================================================
    // bus tasks
    // ============================================================

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge AXIS_ACLK);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge AXIS_ACLK);
        reg_wr    <= 1'b0;
    endtask

    // one bundle in, one output beat back, ends on a falling edge
    task automatic run_bundle(input string name, input int n, input logic stall);
        lanes_t beats [$];
        hv_t    expect_hv [`HD_N_CORES];
        count_t edges;
        logic   hs;
        for (int k = 0; k < n; k++) begin
            beats.push_back(lanes_t'(rand_bits(16)));
        end
        for (int c = 0; c < `HD_N_CORES; c++) begin
            // single beat comes back unchanged
            expect_hv[c] = (n == 1) ? model_mem[lane_of(beats[0], c)] : majority(beats, c);
        end
        @(posedge AXIS_ACLK);
        for (int k = 0; k < n; k++) begin
            in_tvalid <= 1'b1;
            in_tdata  <= beats[k];
            in_tlast  <= (k == n - 1);
            do begin
                @(negedge AXIS_ACLK);
                hs = in_tready;
                @(posedge AXIS_ACLK);
            end while (!hs);
        end
        // now on the edge that took the last beat
        in_tvalid  <= 1'b0;
        in_tlast   <= 1'b0;
        out_tready <= stall ? 1'(rand_bits(1)) : 1'b1;
        edges = '0;
        @(negedge AXIS_ACLK);
        while (!out_tvalid) begin
            check_flag({name, " in_tready busy"}, 1'b0, in_tready);
            @(posedge AXIS_ACLK);
            edges = edges + count_t'(1);
            @(negedge AXIS_ACLK);
        end
        check_count({name, " latency"}, count_t'(2), edges);
        // held under back-pressure until the handshake
        hs = 1'b0;
        while (!hs) begin
            for (int c = 0; c < `HD_N_CORES; c++) begin
                check_hv($sformatf("%s lane %0d", name, c), expect_hv[c],
                         out_tdata[c*`HD_DIM +: `HD_DIM]);
            end
            check_flag({name, " out_tlast"}, 1'b1, out_tlast);
            check_flag({name, " in_tready stalled"}, 1'b0, in_tready);
            hs = out_tready;
            @(posedge AXIS_ACLK);
            out_tready <= hs ? 1'b0 : (stall ? 1'(rand_bits(1)) : 1'b1);
            @(negedge AXIS_ACLK);
        end
        // exactly one beat per bundle
        check_flag({name, " out_tvalid after"}, 1'b0, out_tvalid);
        check_flag({name, " in_tready after"}, 1'b1, in_tready);
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        int n;
        lfsr          = 32'h11eb;
        cycles        = 0;
        S_AXI_ARESETN = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        in_tvalid     = 1'b0;
        in_tdata      = '0;
        in_tlast      = 1'b0;
        out_tready    = 1'b0;
        build_model();
        repeat (3) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(negedge AXIS_ACLK);
        check_flag("reset in_tready", 1'b0, in_tready);
        check_flag("reset out_tvalid", 1'b0, out_tvalid);
        check_flag("reset generating", 1'b0, generating);
        // fill all 16 entries
        write_reg(reg_addr_t'(`HD_REG_COUNT), word_t'(`HD_ITEM_DEPTH));
        write_reg(reg_addr_t'(`HD_REG_CTRL), word_t'(1));
        @(negedge AXIS_ACLK);
        check_flag("gen start", 1'b1, generating);
        while (generating) begin
            check_flag("gen in_tready", 1'b0, in_tready);
            @(negedge AXIS_ACLK);
        end
        check_flag("idle in_tready", 1'b0, in_tready);
        write_reg(reg_addr_t'(`HD_REG_CTRL), word_t'(2));
        @(negedge AXIS_ACLK);
        check_flag("run in_tready", 1'b1, in_tready);
        run_bundle("single beat", 1, 1'b0);
        // odd lengths 3 to 11
        for (int t = 0; t < n_odd; t++) begin
            n = 3 + 2 * int'(rand_bits(3) % 32'd5);
            run_bundle($sformatf("odd %0d", t), n, 1'b0);
        end
        // even lengths 2 to 12, ties use the tie vector
        for (int t = 0; t < n_even; t++) begin
            n = 2 + 2 * int'(rand_bits(3) % 32'd6);
            run_bundle($sformatf("even %0d", t), n, 1'b0);
        end
        for (int t = 0; t < n_stall; t++) begin
            n = 1 + int'(rand_bits(3));
            run_bundle($sformatf("stall %0d", t), n, 1'b1);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
hdl/hd_pkg.sv
hdl/hd_regs.sv
hdl/item_generator.sv
hdl/input_dispatch.sv
hdl/hd_core.sv
hdl/output_stream.sv
hdl/hd_top.sv
bench/tb_hd_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f compile.f --top-module tb_hd_top

run: compile
	@out="$$(./obj_dir/Vtb_hd_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
